// ==== build.f ====
+incdir+hdl
hdl/bypassLsuPkg.sv
hdl/bypassLsu.sv
hdl/uncachedMemCtrl.sv
hdl/mmioDevice.sv
hdl/bypassLsuTop.sv
tests/bypassLsu_assert.sv
tests/bypassLsuTb.sv

// ==== hdl/bypassLsu.sv ====
`timescale 1ns/1ps
`include "bypassLsu_defs.svh"

module bypassLsu (
    input  logic                      clk,
    input  logic                      rst,

    input  bypassLsuPkg::branchProv   branch,

    input  logic                      ldEn,
    input  bypassLsuPkg::ldUop        uopLd,
    output logic                      ldStall,

    input  logic                      stEn,
    input  bypassLsuPkg::stUop        uopSt,
    output logic                      stStall,

    input  logic                      ldResStall,
    output bypassLsuPkg::ldUop        ldRes,
    output logic [31:0]               ldData,

    output bypassLsuPkg::memcReq      memc,
    input  bypassLsuPkg::memcRes      memcIn
);

    bypassLsuPkg::lsuState state;
    bypassLsuPkg::ldUop    activeLd;
    bypassLsuPkg::memcCmd  stCmd;
    bypassLsuPkg::memcCmd  ldCmd;

    logic       stOffer;
    logic       ldOffer;
    logic [1:0] stLow;
    logic       flushActive;
    logic       flushIssue;

    // A load younger than a taken branch is cancelled unless external.
    function automatic logic isFlushed(input bypassLsuPkg::ldUop ld,
                                       input bypassLsuPkg::branchProv br);
        logic signed [`SQN_BITS-1:0] age;
        age = ld.sqN - br.sqN;
        return br.taken && !ld.external && (age > 0);
    endfunction

    assign stOffer = uopSt.valid && stEn;
    assign ldOffer = uopLd.valid && ldEn;

    // Stores win over loads offered in the same cycle.
    assign stStall = stOffer && (state != bypassLsuPkg::IDLE);
    assign ldStall = ldOffer && ((state != bypassLsuPkg::IDLE) || (stOffer && !stStall));

    assign flushActive = activeLd.valid && isFlushed(activeLd, branch);
    assign flushIssue  = isFlushed(uopLd, branch);

    always_comb begin
        ldRes = activeLd;
        ldRes.valid = (state == bypassLsuPkg::DONE_LD) && activeLd.valid && !flushActive;
    end

    // Lowest set mask bit gives the store's byte offset.
    always_comb begin
        stLow = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (uopSt.wmask[i]) begin
                stLow = 2'(i);
            end
        end
    end

    always_comb begin
        case (uopSt.wmask)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: stCmd = bypassLsuPkg::MEMC_WRITE_BYTE;
            4'b0011, 4'b1100:                   stCmd = bypassLsuPkg::MEMC_WRITE_HALF;
            default:                            stCmd = bypassLsuPkg::MEMC_WRITE_WORD;
        endcase
    end

    always_comb begin
        case (uopLd.size)
            2'd0:    ldCmd = bypassLsuPkg::MEMC_READ_BYTE;
            2'd1:    ldCmd = bypassLsuPkg::MEMC_READ_HALF;
            default: ldCmd = bypassLsuPkg::MEMC_READ_WORD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= bypassLsuPkg::IDLE;
            memc.cmd       <= bypassLsuPkg::MEMC_NONE;
            activeLd.valid <= 1'b0;
        end else begin
            // Flushed loads still finish their access but lose the result.
            if (flushActive) begin
                activeLd.valid <= 1'b0;
            end

            case (state)
                bypassLsuPkg::IDLE: begin
                    if (stOffer && !stStall) begin
                        memc.cmd       <= stCmd;
                        memc.writeAddr <= {uopSt.addr[`ADDR_BITS-1:2], stLow};
                        memc.data      <= uopSt.data;
                        state          <= bypassLsuPkg::RQ_ST;
                    end else if (ldOffer && !ldStall && !flushIssue) begin
                        memc.cmd      <= ldCmd;
                        memc.readAddr <= uopLd.addr;
                        activeLd      <= uopLd;
                        state         <= bypassLsuPkg::RQ_LD;
                    end
                end

                bypassLsuPkg::RQ_LD,
                bypassLsuPkg::RQ_ST: begin
                    if (!memcIn.stall) begin
                        memc.cmd <= bypassLsuPkg::MEMC_NONE;
                        state    <= (state == bypassLsuPkg::RQ_LD) ?
                                    bypassLsuPkg::WAIT_LD : bypassLsuPkg::WAIT_ST;
                    end
                end

                bypassLsuPkg::WAIT_LD: begin
                    if (memcIn.sglLdRes.valid) begin
                        // Copy the datum across all byte lanes.
                        case (activeLd.size)
                            2'd0:    ldData <= {4{memcIn.sglLdRes.data[7:0]}};
                            2'd1:    ldData <= {2{memcIn.sglLdRes.data[15:0]}};
                            default: ldData <= memcIn.sglLdRes.data;
                        endcase
                        state <= bypassLsuPkg::DONE_LD;
                    end
                end

                bypassLsuPkg::WAIT_ST: begin
                    if (memcIn.sglStRes.valid) begin
                        state <= bypassLsuPkg::IDLE;
                    end
                end

                bypassLsuPkg::DONE_LD: begin
                    // Held here under back-pressure.
                    if (!ldResStall) begin
                        activeLd.valid <= 1'b0;
                        state          <= bypassLsuPkg::IDLE;
                    end
                end

                default: begin
                    state <= bypassLsuPkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/bypassLsuPkg.sv ====
`include "bypassLsu_defs.svh"

package bypassLsuPkg;

    typedef enum logic [2:0] {
        MEMC_NONE,
        MEMC_READ_BYTE,
        MEMC_READ_HALF,
        MEMC_READ_WORD,
        MEMC_WRITE_BYTE,
        MEMC_WRITE_HALF,
        MEMC_WRITE_WORD
    } memcCmd;

    typedef enum logic [2:0] {
        IDLE,
        RQ_LD,
        RQ_ST,
        WAIT_LD,
        WAIT_ST,
        DONE_LD
    } lsuState;

    typedef struct packed {
        logic taken;
        logic [`SQN_BITS-1:0] sqN;
    } branchProv;

    // Size is 0 for byte, 1 for half, 2 for word.
    typedef struct packed {
        logic valid;
        logic [`ADDR_BITS-1:0] addr;
        logic [1:0] size;
        logic [`SQN_BITS-1:0] sqN;
        logic [5:0] tagDst;
        logic external;
    } ldUop;

    // Data is already placed in its byte lanes.
    typedef struct packed {
        logic valid;
        logic [`ADDR_BITS-1:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
    } stUop;

    typedef struct packed {
        memcCmd cmd;
        logic [`ADDR_BITS-1:0] readAddr;
        logic [`ADDR_BITS-1:0] writeAddr;
        logic [31:0] data;
    } memcReq;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
    } memcLdRes;

    typedef struct packed {
        logic valid;
    } memcStRes;

    typedef struct packed {
        logic stall;
        memcLdRes sglLdRes;
        memcStRes sglStRes;
    } memcRes;

endpackage

// ==== hdl/bypassLsuTop.sv ====
`timescale 1ns/1ps
`include "bypassLsu_defs.svh"

module bypassLsuTop (
    input  logic                    clk,
    input  logic                    rst,

    input  bypassLsuPkg::branchProv branch,

    input  logic                    ldEn,
    input  bypassLsuPkg::ldUop      uopLd,
    output logic                    ldStall,

    input  logic                    stEn,
    input  bypassLsuPkg::stUop      uopSt,
    output logic                    stStall,

    input  logic                    ldResStall,
    output bypassLsuPkg::ldUop      ldRes,
    output logic [31:0]             ldData
);

    bypassLsuPkg::memcReq memcReq;
    bypassLsuPkg::memcRes memcRes;

    logic                           devStart;
    logic                           devWrite;
    logic [$clog2(`MMIO_WORDS)-1:0] devIndex;
    logic [3:0]                     devLanes;
    logic [31:0]                    devWdata;
    logic [31:0]                    devRdata;
    logic                           devDone;

    bypassLsu lsu_i (
        .clk        (clk),
        .rst        (rst),
        .branch     (branch),
        .ldEn       (ldEn),
        .uopLd      (uopLd),
        .ldStall    (ldStall),
        .stEn       (stEn),
        .uopSt      (uopSt),
        .stStall    (stStall),
        .ldResStall (ldResStall),
        .ldRes      (ldRes),
        .ldData     (ldData),
        .memc       (memcReq),
        .memcIn     (memcRes)
    );

    uncachedMemCtrl memc_i (
        .clk      (clk),
        .rst      (rst),
        .req      (memcReq),
        .res      (memcRes),
        .devStart (devStart),
        .devWrite (devWrite),
        .devIndex (devIndex),
        .devLanes (devLanes),
        .devWdata (devWdata),
        .devRdata (devRdata),
        .devDone  (devDone)
    );

    mmioDevice dev_i (
        .clk   (clk),
        .rst   (rst),
        .start (devStart),
        .write (devWrite),
        .index (devIndex),
        .lanes (devLanes),
        .wdata (devWdata),
        .rdata (devRdata),
        .done  (devDone)
    );

endmodule

// ==== hdl/bypassLsu_defs.svh ====
`ifndef BYPASS_LSU_DEFS_SVH
`define BYPASS_LSU_DEFS_SVH

// Byte address width.
`define ADDR_BITS 32

// Sequence number width. Ages compare by signed difference.
`define SQN_BITS 7

// Number of 32-bit words in the device memory.
`define MMIO_WORDS 256

// Device cycles from access start to data.
`define MMIO_LATENCY 3

`endif

// ==== hdl/mmioDevice.sv ====
`timescale 1ns/1ps
`include "bypassLsu_defs.svh"

module mmioDevice (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           start,
    input  logic                           write,
    input  logic [$clog2(`MMIO_WORDS)-1:0] index,
    input  logic [3:0]                     lanes,
    input  logic [31:0]                    wdata,

    output logic [31:0]                    rdata,
    output logic                           done
);

    logic [31:0]               mem [`MMIO_WORDS];
    logic [31:0]               dataPipe [`MMIO_LATENCY];
    logic [`MMIO_LATENCY-1:0]  donePipe;

    always_ff @(posedge clk) begin
        if (start && write) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    mem[index][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end

        // Read word enters the latency pipeline with the start pulse.
        dataPipe[0] <= mem[index];
        for (int s = 1; s < `MMIO_LATENCY; s++) begin
            dataPipe[s] <= dataPipe[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            donePipe <= '0;
        end else begin
            donePipe <= {donePipe[`MMIO_LATENCY-2:0], start};
        end
    end

    assign done  = donePipe[`MMIO_LATENCY-1];
    assign rdata = dataPipe[`MMIO_LATENCY-1];

endmodule

// ==== hdl/uncachedMemCtrl.sv ====
`timescale 1ns/1ps
`include "bypassLsu_defs.svh"

module uncachedMemCtrl (
    input  logic                              clk,
    input  logic                              rst,

    input  bypassLsuPkg::memcReq              req,
    output bypassLsuPkg::memcRes              res,

    output logic                              devStart,
    output logic                              devWrite,
    output logic [$clog2(`MMIO_WORDS)-1:0]    devIndex,
    output logic [3:0]                        devLanes,
    output logic [31:0]                       devWdata,
    input  logic [31:0]                       devRdata,
    input  logic                              devDone
);

    localparam int IdxBits = $clog2(`MMIO_WORDS);

    bypassLsuPkg::memcCmd kind;

    logic                  busy;
    logic [1:0]            low;
    logic                  ldPulse;
    logic                  stPulse;
    logic [31:0]           ldWord;
    logic                  accept;
    logic                  isWrite;
    logic                  kindWrite;
    logic                  finish;
    logic [`ADDR_BITS-1:0] addr;
    logic [3:0]            lanes;

    assign accept  = (req.cmd != bypassLsuPkg::MEMC_NONE) && !busy;
    assign isWrite = req.cmd inside {bypassLsuPkg::MEMC_WRITE_BYTE,
                                     bypassLsuPkg::MEMC_WRITE_HALF,
                                     bypassLsuPkg::MEMC_WRITE_WORD};
    assign kindWrite = kind inside {bypassLsuPkg::MEMC_WRITE_BYTE,
                                    bypassLsuPkg::MEMC_WRITE_HALF,
                                    bypassLsuPkg::MEMC_WRITE_WORD};
    assign addr    = isWrite ? req.writeAddr : req.readAddr;
    assign finish  = busy && devDone;

    // Write lanes rebuilt from the command and the low address bits.
    always_comb begin
        case (req.cmd)
            bypassLsuPkg::MEMC_WRITE_BYTE: lanes = 4'b0001 << addr[1:0];
            bypassLsuPkg::MEMC_WRITE_HALF: lanes = addr[1] ? 4'b1100 : 4'b0011;
            bypassLsuPkg::MEMC_WRITE_WORD: lanes = 4'b1111;
            default:                       lanes = 4'b0000;
        endcase
    end

    always_comb begin
        res.stall          = busy;
        res.sglLdRes.valid = ldPulse;
        res.sglLdRes.data  = ldWord;
        res.sglStRes.valid = stPulse;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            devStart <= 1'b0;
            ldPulse  <= 1'b0;
            stPulse  <= 1'b0;
        end else begin
            devStart <= accept;
            ldPulse  <= 1'b0;
            stPulse  <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy    <= 1'b0;
                ldPulse <= !kindWrite;
                stPulse <= kindWrite;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            kind     <= req.cmd;
            low      <= addr[1:0];
            devIndex <= addr[2 +: IdxBits];
            devLanes <= lanes;
            devWdata <= req.data;
            devWrite <= isWrite;
        end
        // Move the addressed bytes down to lane 0.
        if (finish) begin
            ldWord <= devRdata >> {low, 3'b000};
        end
    end

endmodule

// ==== tests/bypassLsuTb.sv ====
`timescale 1ns/1ps
`include "bypassLsu_defs.svh"

module bypassLsuTb;

    localparam int NumOps = 420;
    localparam int MaxBp = 8;
    localparam longint Timeout = 2 * NumOps * (`MMIO_LATENCY + 3 + MaxBp) * 10;
    localparam int IdxBits = $clog2(`MMIO_WORDS);

    logic clk;
    logic rst;
    bypassLsuPkg::branchProv branch;
    logic ldEn;
    logic stEn;
    logic ldResStall;
    bypassLsuPkg::ldUop uopLd;
    bypassLsuPkg::stUop uopSt;
    logic ldStall;
    logic stStall;
    bypassLsuPkg::ldUop ldRes;
    logic [31:0] ldData;

    int errors = 0;
    int enPct = 100;
    int bpLeft = 0;
    bit bpEnable = 0;
    bit stTaken = 0;
    bit ldTaken = 0;
    logic [`SQN_BITS-1:0] nextSqN = '0;
    logic [31:0] shadow [`MMIO_WORDS];
    bypassLsuPkg::ldUop expUop[$];
    logic [31:0] expData[$];

    bypassLsuTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(Timeout);
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    // A load younger than a taken branch is cancelled unless external.
    function automatic bit wouldCancel(input bypassLsuPkg::ldUop ld,
                                       input bypassLsuPkg::branchProv br);
        logic signed [`SQN_BITS-1:0] age;
        age = ld.sqN - br.sqN;
        return br.taken && !ld.external && (age > 0);
    endfunction

    function automatic logic [31:0] expectedLoad(input logic [31:0] addr, input logic [1:0] size);
        logic [31:0] sh;
        sh = shadow[addr[2 +: IdxBits]] >> (8 * addr[1:0]);
        case (size)
            2'd0:    return {4{sh[7:0]}};
            2'd1:    return {2{sh[15:0]}};
            default: return sh;
        endcase
    endfunction

    function automatic logic [31:0] fillWord(input int i);
        logic [7:0] b;
        b = i[7:0];
        return {~b, b ^ 8'h5a, b + 8'h33, b};
    endfunction

    function automatic logic randEn();
        return $urandom_range(99) < enPct;
    endfunction

    // Looks at the settled values just before each rising edge.
    task automatic checkCycle();
        bit stAcc;
        bit ldAcc;
        stAcc = uopSt.valid && stEn && !stStall;
        ldAcc = uopLd.valid && ldEn && !ldStall;
        if ((stAcc || ldAcc) && expUop.size() > 0) begin
            errors++;
            $display("New access accepted at %0t while a load was pending", $time);
        end
        if (expUop.size() > 0 && wouldCancel(expUop[0], branch)) begin
            void'(expUop.pop_front());
            void'(expData.pop_front());
        end
        if (ldRes.valid) begin
            if (expUop.size() == 0) begin
                errors++;
                $display("Unexpected load result at %0t with sqN %0d", $time, ldRes.sqN);
            end else begin
                if (ldData !== expData[0]) begin
                    errors++;
                    $display("ERR %0t ldData exp %h got %h", $time, expData[0], ldData);
                end
                if (ldRes.tagDst !== expUop[0].tagDst) begin
                    errors++;
                    $display("ERR %0t ldRes.tagDst exp %h got %h", $time,
                             expUop[0].tagDst, ldRes.tagDst);
                end
                if (ldRes.sqN !== expUop[0].sqN) begin
                    errors++;
                    $display("ERR %0t ldRes.sqN exp %h got %h", $time,
                             expUop[0].sqN, ldRes.sqN);
                end
                if (ldRes.addr !== expUop[0].addr) begin
                    errors++;
                    $display("ERR %0t ldRes.addr exp %h got %h", $time,
                             expUop[0].addr, ldRes.addr);
                end
                if (ldRes.size !== expUop[0].size) begin
                    errors++;
                    $display("ERR %0t ldRes.size exp %h got %h", $time,
                             expUop[0].size, ldRes.size);
                end
                if (ldRes.external !== expUop[0].external) begin
                    errors++;
                    $display("ERR %0t ldRes.external exp %h got %h", $time,
                             expUop[0].external, ldRes.external);
                end
                if (!ldResStall) begin
                    void'(expUop.pop_front());
                    void'(expData.pop_front());
                end
            end
        end
        if (stAcc) begin
            stTaken = 1'b1;
            for (int i = 0; i < 4; i++) begin
                if (uopSt.wmask[i]) begin
                    shadow[uopSt.addr[2 +: IdxBits]][8*i +: 8] = uopSt.data[8*i +: 8];
                end
            end
        end
        if (ldAcc) begin
            ldTaken = 1'b1;
            if (!wouldCancel(uopLd, branch)) begin
                expUop.push_back(uopLd);
                expData.push_back(expectedLoad(uopLd.addr, uopLd.size));
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge clk);
            #4;
            stTaken = 1'b0;
            ldTaken = 1'b0;
            if (!rst) begin
                checkCycle();
            end
        end
    end

    // Back-pressure bursts, each followed by one released cycle.
    initial begin
        forever begin
            @(negedge clk);
            if (!bpEnable) begin
                ldResStall = 1'b0;
            end else if (bpLeft > 0) begin
                ldResStall = 1'b1;
                bpLeft--;
            end else begin
                ldResStall = 1'b0;
                bpLeft = $urandom_range(MaxBp);
            end
        end
    end

    task automatic sendStore(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        @(negedge clk);
        uopSt.valid = 1'b1;
        uopSt.addr  = addr;
        uopSt.data  = data;
        uopSt.wmask = mask;
        stEn = randEn();
        forever begin
            @(negedge clk);
            if (stTaken) break;
            stEn = randEn();
        end
        uopSt.valid = 1'b0;
        stEn = 1'b0;
    endtask

    task automatic sendLoad(input logic [31:0] addr, input logic [1:0] size, input bit ext,
                            input bit brTaken, input logic [`SQN_BITS-1:0] brSqN);
        @(negedge clk);
        uopLd.valid    = 1'b1;
        uopLd.addr     = addr;
        uopLd.size     = size;
        uopLd.sqN      = nextSqN;
        uopLd.tagDst   = 6'($urandom);
        uopLd.external = ext;
        branch.taken   = brTaken;
        branch.sqN     = brSqN;
        nextSqN++;
        ldEn = randEn();
        forever begin
            @(negedge clk);
            if (ldTaken) break;
            ldEn = randEn();
        end
        uopLd.valid  = 1'b0;
        ldEn         = 1'b0;
        branch.taken = 1'b0;
    endtask

    task automatic pulseBranch(input logic [`SQN_BITS-1:0] sqN);
        branch.taken = 1'b1;
        branch.sqN   = sqN;
        @(negedge clk);
        branch.taken = 1'b0;
    endtask

    task automatic readAll(input int idx);
        sendLoad(idx * 4, 2'd2, 1'b0, 1'b0, '0);
        sendLoad(idx * 4, 2'd1, 1'b0, 1'b0, '0);
        sendLoad(idx * 4 + 2, 2'd1, 1'b0, 1'b0, '0);
        for (int b = 0; b < 4; b++) begin
            sendLoad(idx * 4 + b, 2'd0, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic settle();
        repeat (2 * `MMIO_LATENCY + 6) @(negedge clk);
    endtask

    initial begin
        int seedDummy;
        int idx;
        int sz;
        int off;
        logic [3:0] mask;
        seedDummy = $urandom(46);
        rst = 1'b1;
        branch = '0;
        ldEn = 1'b0;
        stEn = 1'b0;
        uopLd = '0;
        uopSt = '0;
        ldResStall = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        repeat (5) begin
            @(negedge clk);
            #1;
            if (ldStall || stStall || ldRes.valid) begin
                errors++;
                $display("Outputs active at %0t with no micro-op offered", $time);
            end
        end

        for (int i = 0; i < 16; i++) begin
            sendStore(i * 4, fillWord(i), 4'hf);
        end

        // Word, half and byte stores at every lane position.
        for (int p = 0; p < 7; p++) begin
            case (p)
                0:       mask = 4'hf;
                1:       mask = 4'h3;
                2:       mask = 4'hc;
                default: mask = 4'b0001 << (p - 3);
            endcase
            sendStore((2 + p) * 4, $urandom, mask);
            readAll(2 + p);
        end

        // Store and load offered together.
        settle();
        @(negedge clk);
        uopSt = '{valid: 1'b1, addr: 32'h24, data: 32'hcafe_f00d, wmask: 4'hf};
        uopLd = '{valid: 1'b1, addr: 32'h24, size: 2'd2, sqN: nextSqN, tagDst: 6'h2a,
                  external: 1'b0};
        nextSqN++;
        stEn = 1'b1;
        ldEn = 1'b1;
        #1;
        if (stStall || !ldStall) begin
            errors++;
            $display("Store did not win over the load at %0t", $time);
        end
        while (!stTaken) @(negedge clk);
        uopSt.valid = 1'b0;
        while (!ldTaken) @(negedge clk);
        uopLd.valid = 1'b0;
        stEn = 1'b0;
        ldEn = 1'b0;

        bpEnable = 1'b1;
        for (int i = 0; i < 5; i++) begin
            sendLoad(i * 4, 2'd2, 1'b0, 1'b0, '0);
            sendStore(i * 4, $urandom, 4'h3);
            sendLoad(i * 4 + 1, 2'd0, 1'b0, 1'b0, '0);
        end
        settle();
        bpEnable = 1'b0;
        settle();

        // Branch flushes at issue and in flight, then immune loads.
        nextSqN = 7'd10;
        sendLoad(32'h8, 2'd2, 1'b0, 1'b1, 7'd5);
        sendLoad(32'hc, 2'd2, 1'b0, 1'b0, '0);
        pulseBranch(7'd5);
        settle();
        sendLoad(32'h10, 2'd2, 1'b1, 1'b1, 7'd5);
        nextSqN = 7'd3;
        sendLoad(32'h14, 2'd1, 1'b0, 1'b1, 7'd5);
        settle();

        bpEnable = 1'b1;
        enPct = 70;
        for (int n = 0; n < 300; n++) begin
            idx = $urandom_range(15);
            sz = $urandom_range(2);
            off = (sz == 0) ? $urandom_range(3) : (sz == 1) ? 2 * $urandom_range(1) : 0;
            if ($urandom_range(99) < 40) begin
                mask = (sz == 0) ? (4'b0001 << off) : (sz == 1) ? (4'b0011 << off) : 4'hf;
                sendStore(idx * 4, $urandom, mask);
            end else begin
                sendLoad(idx * 4 + off, 2'(sz), $urandom_range(99) < 20,
                         $urandom_range(99) < 15, nextSqN + 7'($urandom_range(20)) - 7'd10);
                if ($urandom_range(99) < 10) begin
                    pulseBranch(nextSqN - 7'($urandom_range(6)));
                end
            end
        end
        settle();
        bpEnable = 1'b0;
        settle();

        if (expUop.size() != 0) begin
            errors++;
            $display("%0d expected load results never appeared", expUop.size());
        end
        errors += dut_i.lsu_i.assert_i.failCount;
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tests/bypassLsu_assert.sv ====
`timescale 1ns/1ps

module bypassLsuAssert (
    input logic                  clk,
    input logic                  rst,
    input bypassLsuPkg::lsuState state,
    input bypassLsuPkg::memcReq  memc,
    input bypassLsuPkg::memcRes  memcIn,
    input bypassLsuPkg::ldUop    ldRes,
    input logic [31:0]           ldData,
    input logic                  ldResStall,
    input logic                  ldStall,
    input logic                  stStall,
    input logic                  stEn,
    input bypassLsuPkg::stUop    uopSt
);

    int failCount = 0;

    // A pending request stays put while the controller is busy and clears once taken.
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        (memc.cmd != bypassLsuPkg::MEMC_NONE) |=>
            ($past(memcIn.stall) ? $stable(memc) : (memc.cmd == bypassLsuPkg::MEMC_NONE)))
        else begin
            failCount++;
            $error("controller request not held until taken");
        end

    // Back-pressure freezes the load result.
    resultHeld: assert property (@(posedge clk) disable iff (rst)
        (ldRes.valid && ldResStall) |=> ($stable(ldData) && $stable(ldRes.tagDst)
                                         && $stable(ldRes.sqN) && $stable(ldRes.addr)))
        else begin
            failCount++;
            $error("load result changed under back-pressure");
        end

    // A valid result follows a load completion and lasts only in DONE_LD.
    validInDone: assert property (@(posedge clk) disable iff (rst)
        ldRes.valid |-> (state == bypassLsuPkg::DONE_LD
                         && ($past(memcIn.sglLdRes.valid) || $past(ldRes.valid))))
        else begin
            failCount++;
            $error("load result valid outside DONE_LD");
        end

    // The sequencer is back in IDLE and ready right after an access completes.
    idleNoStall: assert property (@(posedge clk) disable iff (rst)
        (($past(memcIn.sglStRes.valid)
          || $past(state == bypassLsuPkg::DONE_LD && !ldResStall))
         && !(uopSt.valid && stEn))
        |-> (state == bypassLsuPkg::IDLE && !stStall && !ldStall))
        else begin
            failCount++;
            $error("stall raised in IDLE without a competing store");
        end

endmodule

bind bypassLsu bypassLsuAssert assert_i (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .memc       (memc),
    .memcIn     (memcIn),
    .ldRes      (ldRes),
    .ldData     (ldData),
    .ldResStall (ldResStall),
    .ldStall    (ldStall),
    .stStall    (stStall),
    .stEn       (stEn),
    .uopSt      (uopSt)
);
